//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then search the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f sim.f --top-module virtual_port_udp_tb -o virtual_port_udp_sim \
    && ./obj_dir/virtual_port_udp_sim | tee /dev/stderr | grep -qx 'All tests passed!' \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }

//--- sim.f
+incdir+source
+incdir+tb
source/udp_port_pkg.sv
source/udp_frame_parser.sv
source/payload_fifo.sv
source/udp_receive_handler.sv
source/virtual_port_udp.sv
tb/virtual_port_udp_tb.sv

//--- source/payload_fifo.sv
`include "udp_port_settings.svh"

module payload_fifo (
    input  wire                         clock,
    input  wire                         rst_n,
    input  udp_port_pkg::stream_word_t  write_data,
    input  wire                         write_enable,
    input  wire                         commit,
    input  wire                         discard,
    input  wire                         read_enable,

    output udp_port_pkg::stream_word_t  read_data,
    output logic                        full,
    output logic                        empty
);

    import udp_port_pkg::*;

    localparam int ADDR_WIDTH = $clog2(`UDP_PAYLOAD_DEPTH);

    stream_word_t   memory [`UDP_PAYLOAD_DEPTH];

    fifo_ptr_t      write_pointer;
    fifo_ptr_t      commit_pointer;     // End of the last accepted frame
    fifo_ptr_t      read_pointer;
    fifo_ptr_t      write_pointer_next;
    logic           write_accept;

    ////////////////////////////////////////////////////////////////////////////
    // Status
    ////////////////////////////////////////////////////////////////////////////

    assign write_accept       = write_enable && !discard && !full;
    assign write_pointer_next = write_pointer + fifo_ptr_t'(write_accept);

    // Uncommitted words take space but are not readable
    assign full  = (write_pointer[ADDR_WIDTH] != read_pointer[ADDR_WIDTH]) &&
                   (write_pointer[ADDR_WIDTH-1:0] == read_pointer[ADDR_WIDTH-1:0]);
    assign empty = (read_pointer == commit_pointer);

    ////////////////////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_pointer  <= '0;
            commit_pointer <= '0;
            read_pointer   <= '0;
        end else begin
            if (discard) begin
                write_pointer <= commit_pointer;        // Roll back the frame
            end else begin
                write_pointer <= write_pointer_next;
            end
            // Word written with the commit belongs to the frame
            if (commit) begin
                commit_pointer <= write_pointer_next;
            end
            if (read_enable && !empty) begin
                read_pointer <= read_pointer + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (write_accept) begin
            memory[write_pointer[ADDR_WIDTH-1:0]] <= write_data;
        end
        if (read_enable) begin
            read_data <= memory[read_pointer[ADDR_WIDTH-1:0]];
        end
    end

    a_no_read_when_empty: assert property (@(posedge clock) disable iff (!rst_n)
        read_enable |-> !empty)
        else $error("payload read while FIFO empty");

    a_commit_behind_write: assert property (@(posedge clock) disable iff (!rst_n)
        fifo_ptr_t'(write_pointer - commit_pointer) <= fifo_ptr_t'(`UDP_PAYLOAD_DEPTH))
        else $error("committed pointer passed write pointer");

endmodule

//--- source/udp_frame_parser.sv
`include "udp_port_settings.svh"

module udp_frame_parser (
    input  wire                         clock,
    input  wire                         rst_n,
    input  udp_port_pkg::stream_word_t  receive_data,
    input  wire                         receive_data_enable,
    input  udp_port_pkg::port_t         listen_port,
    input  wire                         full,

    output udp_port_pkg::stream_word_t  write_data,
    output logic                        write_enable,
    output logic                        commit,
    output logic                        discard,
    output udp_port_pkg::count_t        drop_count
);

    import udp_port_pkg::*;

    localparam int                      POS_WIDTH     = 3;
    localparam int                      SUM_WIDTH     = `UDP_PORT_WIDTH;
    localparam logic [POS_WIDTH-1:0]    POS_PORT_HIGH = POS_WIDTH'(0);
    localparam logic [POS_WIDTH-1:0]    POS_PORT_LOW  = POS_WIDTH'(1);
    localparam logic [POS_WIDTH-1:0]    POS_MIN_LAST  = POS_WIDTH'(3);
    localparam logic [POS_WIDTH-1:0]    POS_PAYLOAD   = POS_WIDTH'(4);   // Saturates here

    logic [POS_WIDTH-1:0]   position;
    logic                   odd_byte;
    byte_t                  high_byte;
    port_t                  frame_port;
    logic [SUM_WIDTH-1:0]   sum;

    byte_t                  delay_near;         // Previous byte
    byte_t                  delay_far;          // Two bytes back

    logic                   pend_valid;
    stream_word_t           pend_word;
    logic                   end_pulse;
    logic                   frame_ok;
    logic                   overflow;

    logic [SUM_WIDTH-1:0]   sum_word;
    logic [SUM_WIDTH:0]     sum_wide;
    logic [SUM_WIDTH-1:0]   sum_next;
    logic                   length_ok;
    logic                   overflow_now;

    ////////////////////////////////////////////////////////////////////////////
    // Ones' complement checksum
    ////////////////////////////////////////////////////////////////////////////

    // Odd trailing byte gets a zero low byte
    always_comb begin
        if (odd_byte) begin
            sum_word = {high_byte, receive_data.data};
        end else begin
            sum_word = {receive_data.data, {`UDP_DATA_WIDTH{1'b0}}};
        end
    end

    assign sum_wide  = {1'b0, sum} + {1'b0, sum_word};
    assign sum_next  = sum_wide[SUM_WIDTH-1:0] + SUM_WIDTH'(sum_wide[SUM_WIDTH]);   // End-around carry
    assign length_ok = (position >= POS_MIN_LAST);

    ////////////////////////////////////////////////////////////////////////////
    // Verdict and FIFO control
    ////////////////////////////////////////////////////////////////////////////

    // Last pending write may still meet a full FIFO
    assign overflow_now = overflow || (pend_valid && full);

    assign write_data   = pend_word;
    assign write_enable = pend_valid && !overflow_now;
    assign commit       = end_pulse && frame_ok && !overflow_now;
    assign discard      = end_pulse && !(frame_ok && !overflow_now);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            position   <= '0;
            odd_byte   <= 1'b0;
            sum        <= '0;
            pend_valid <= 1'b0;
            end_pulse  <= 1'b0;
            frame_ok   <= 1'b0;
            overflow   <= 1'b0;
            drop_count <= '0;
        end else begin
            pend_valid <= receive_data_enable && (position == POS_PAYLOAD);
            end_pulse  <= receive_data_enable && receive_data.last;

            if (receive_data_enable) begin
                if (receive_data.last) begin
                    position <= '0;
                    odd_byte <= 1'b0;
                    sum      <= '0;
                    frame_ok <= length_ok && (frame_port == listen_port) &&
                                (sum_next == `UDP_CHECKSUM_GOOD);
                end else begin
                    if (position != POS_PAYLOAD) begin
                        position <= position + 1'b1;
                    end
                    odd_byte <= !odd_byte;
                    if (odd_byte) begin
                        sum <= sum_next;
                    end
                end
            end

            // Sticky until the frame is judged
            if (end_pulse) begin
                overflow <= 1'b0;
            end else if (pend_valid && full) begin
                overflow <= 1'b1;
            end

            if (discard) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Port capture and payload delay line
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (receive_data_enable) begin
            delay_far  <= delay_near;
            delay_near <= receive_data.data;
            if (!odd_byte) begin
                high_byte <= receive_data.data;
            end
            if (position == POS_PORT_HIGH) begin
                frame_port[`UDP_PORT_WIDTH-1 -: `UDP_DATA_WIDTH] <= receive_data.data;
            end
            if (position == POS_PORT_LOW) begin
                frame_port[`UDP_DATA_WIDTH-1:0] <= receive_data.data;
            end
            // Checksum bytes never reach the FIFO
            if (position == POS_PAYLOAD) begin
                pend_word.last <= receive_data.last;
                pend_word.data <= delay_far;
            end
        end
    end

    a_last_word_with_verdict: assert property (@(posedge clock) disable iff (!rst_n)
        write_enable |-> (write_data.last == (commit || discard)))
        else $error("payload write out of step with the frame verdict");

    a_no_write_after_overflow: assert property (@(posedge clock) disable iff (!rst_n)
        (pend_valid && full && !end_pulse) |=> !write_enable)
        else $error("payload write after the frame overflowed");

endmodule

//--- source/udp_port_pkg.sv
`include "udp_port_settings.svh"

package udp_port_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stream types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`UDP_DATA_WIDTH-1:0] byte_t;

    // Word on the switch interface, in the FIFO and on the output
    typedef struct packed {
        logic   last;                   // Final byte of a frame
        byte_t  data;
    } stream_word_t;

    ////////////////////////////////////////////////////////////////////////////
    // Header fields and statistics
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`UDP_PORT_WIDTH-1:0]  port_t;
    typedef logic [`UDP_COUNT_WIDTH-1:0] count_t;

    // Extra top bit tells a full FIFO from an empty one
    typedef logic [$clog2(`UDP_PAYLOAD_DEPTH):0] fifo_ptr_t;

endpackage

//--- source/udp_port_settings.svh
`ifndef UDP_PORT_SETTINGS_SVH
`define UDP_PORT_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Stream and word widths
////////////////////////////////////////////////////////////////////////////

`define UDP_DATA_WIDTH      8           // One stream byte
`define UDP_PORT_WIDTH      16          // Port and checksum words

////////////////////////////////////////////////////////////////////////////
// Buffering and statistics
////////////////////////////////////////////////////////////////////////////

// Payload entries held between parser and handler
`define UDP_PAYLOAD_DEPTH   1024

`define UDP_COUNT_WIDTH     16          // Packet and drop counters

// Folded ones' complement sum over a frame with a correct checksum
`define UDP_CHECKSUM_GOOD   16'hFFFF

`endif

//--- source/udp_receive_handler.sv
module udp_receive_handler (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire                         empty,
    input  udp_port_pkg::stream_word_t  read_data,
    input  wire                         transmit_data_enable,

    output logic                        read_enable,
    output udp_port_pkg::stream_word_t  transmit_data,
    output logic                        transmit_data_valid,
    output udp_port_pkg::count_t        packet_count
);

    ////////////////////////////////////////////////////////////////////////////
    // Drain towards the switch
    ////////////////////////////////////////////////////////////////////////////

    // Only committed payload, only while the switch takes it
    assign read_enable = !empty && transmit_data_enable;

    // FIFO output register holds the word for this cycle
    assign transmit_data = read_data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            transmit_data_valid <= 1'b0;
        end else begin
            transmit_data_valid <= read_enable;     // Read latency is one cycle
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Delivered packet statistic
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            packet_count <= '0;
        end else if (transmit_data_valid && transmit_data.last) begin
            packet_count <= packet_count + 1'b1;
        end
    end

    a_no_lost_payload: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(empty) |-> $past(read_enable))
        else $error("committed payload left the FIFO without a read");

endmodule

//--- source/virtual_port_udp.sv
module virtual_port_udp (
    input  wire                         clock,
    input  wire                         rst_n,
    input  udp_port_pkg::port_t         listen_port,
    input  udp_port_pkg::stream_word_t  receive_data,           // From switch
    input  wire                         receive_data_enable,    // From switch
    input  wire                         transmit_data_enable,   // From switch

    output udp_port_pkg::stream_word_t  transmit_data,          // To switch
    output logic                        transmit_data_valid,    // To switch
    output udp_port_pkg::count_t        packet_count,
    output udp_port_pkg::count_t        drop_count
);

    import udp_port_pkg::*;

    stream_word_t   fifo_write_data;
    logic           fifo_write_enable;
    logic           fifo_commit;
    logic           fifo_discard;
    logic           fifo_full;
    stream_word_t   fifo_read_data;
    logic           fifo_read_enable;
    logic           fifo_empty;

    udp_frame_parser udp_frame_parser (
        .clock                  (clock),
        .rst_n                  (rst_n),
        .receive_data           (receive_data),
        .receive_data_enable    (receive_data_enable),
        .listen_port            (listen_port),
        .full                   (fifo_full),
        .write_data             (fifo_write_data),
        .write_enable           (fifo_write_enable),
        .commit                 (fifo_commit),
        .discard                (fifo_discard),
        .drop_count             (drop_count)
    );

    payload_fifo payload_fifo (
        .clock                  (clock),
        .rst_n                  (rst_n),
        .write_data             (fifo_write_data),
        .write_enable           (fifo_write_enable),
        .commit                 (fifo_commit),
        .discard                (fifo_discard),
        .read_enable            (fifo_read_enable),
        .read_data              (fifo_read_data),
        .full                   (fifo_full),
        .empty                  (fifo_empty)
    );

    udp_receive_handler udp_receive_handler (
        .clock                  (clock),
        .rst_n                  (rst_n),
        .empty                  (fifo_empty),
        .read_data              (fifo_read_data),
        .transmit_data_enable   (transmit_data_enable),
        .read_enable            (fifo_read_enable),
        .transmit_data          (transmit_data),
        .transmit_data_valid    (transmit_data_valid),
        .packet_count           (packet_count)
    );

endmodule

//--- tb/udp_trace.txt
# frame <deliver|drop> <hold|run> <hex bytes, port first, checksum last>
# gen <deliver|drop> <hold|run> <port hex> <payload length> / end <test name>
frame deliver run 1f9001020304dc69
end good_frame
frame drop run 1f9001020304dc68
frame drop run 1f9101020304dc68
frame drop run 1f90ff
frame drop run 1f
frame deliver run 1f90aabbccb369
end bad_frames
gen deliver hold 1f90 7
gen deliver hold 1f90 40
frame deliver hold 1f905a6f86
gen deliver hold 1f90 1
gen deliver hold 1f90 100
end held_output
gen drop hold 1f90 1100
gen deliver run 1f90 12
end overflow
frame deliver run 1f90e06f
end empty_payload
gen deliver run 1f90 33
gen drop run 1f91 20
gen deliver run 1f90 2
frame deliver run 1f9001020304dc69
gen deliver run 1f90 64
gen deliver run 1f90 5
end random_stalls

//--- tb/udp_tb_checks.svh
`ifndef UDP_TB_CHECKS_SVH
`define UDP_TB_CHECKS_SVH

logic [15:0] lfsr_state;

// Fibonacci form with taps 16 14 13 11
function automatic logic next_lfsr_bit();
    logic feedback;
    feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], feedback};
    return feedback;
endfunction

function automatic byte_t random_byte();
    byte_t value;
    value = '0;
    for (int i = 0; i < 8; i++) begin
        value = {value[6:0], next_lfsr_bit()};
    end
    return value;
endfunction

// Ones' complement sum of byte pairs, odd byte padded low
function automatic port_t ones_sum(input byte_t bytes[$]);
    logic [16:0] total;
    port_t       word;
    total = '0;
    for (int i = 0; i < bytes.size(); i += 2) begin
        word  = {bytes[i], (i + 1 < bytes.size()) ? bytes[i + 1] : 8'h00};
        total = {1'b0, total[15:0]} + {1'b0, word};
        total = {1'b0, total[15:0]} + 17'(total[16]);     // End-around carry
    end
    return total[15:0];
endfunction

task automatic check_word(input stream_word_t actual, input stream_word_t expected,
                          input string what);
    if (actual !== expected) begin
        $display("** Error at %0t: %s expected last %b data %h, got last %b data %h",
                 $time, what, expected.last, expected.data, actual.last, actual.data);
        error_count++;
        test_errors++;
    end
endtask

task automatic check_count(input count_t actual, input count_t expected, input string what);
    if (actual !== expected) begin
        $display("** Error at %0t: %s expected %0d, got %0d", $time, what, expected, actual);
        error_count++;
        test_errors++;
    end
endtask

task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
        $display("** Error at %0t: %s expected %b, got %b", $time, what, expected, actual);
        error_count++;
        test_errors++;
    end
endtask

`endif

//--- tb/virtual_port_udp_tb.sv
module virtual_port_udp_tb;

    import udp_port_pkg::*;

    localparam int      CLOCK_PERIOD  = 10;
    localparam int      RESET_CYCLES  = 3;
    localparam int      DRAIN_TIMEOUT = 5000;
    localparam int      SETTLE_CYCLES = 4;          // Verdict and counter latency
    localparam port_t   LISTEN_PORT   = 16'h1F90;
    localparam string   TRACE_FILE    = "tb/udp_trace.txt";

    logic           clock;
    logic           rst_n;
    stream_word_t   receive_data;
    logic           receive_data_enable;
    logic           transmit_data_enable;
    stream_word_t   transmit_data;
    logic           transmit_data_valid;
    count_t         packet_count;
    count_t         drop_count;

    stream_word_t   expected_words[$];
    byte_t          frame_bytes[$];
    count_t         expected_packets;
    count_t         expected_drops;
    logic           hold_output;
    logic           timed_out;
    int             error_count;
    int             test_errors;
    int             tests_run;
    int             tests_failed;

    `include "udp_tb_checks.svh"

    virtual_port_udp virtual_port_udp_i (
        .clock                  (clock),
        .rst_n                  (rst_n),
        .listen_port            (LISTEN_PORT),
        .receive_data           (receive_data),
        .receive_data_enable    (receive_data_enable),
        .transmit_data_enable   (transmit_data_enable),
        .transmit_data          (transmit_data),
        .transmit_data_valid    (transmit_data_valid),
        .packet_count           (packet_count),
        .drop_count             (drop_count)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Cycle driver and scoreboard
    ////////////////////////////////////////////////////////////////////////////

    // Registered outputs are stable at the falling edge
    task automatic step_cycle(input logic valid, input stream_word_t word);
        @(negedge clock);
        // Enable still holds the level seen at the last rising edge
        if (transmit_data_valid && !transmit_data_enable) begin
            $display("Output word %h at time %0t arrived while transmit enable was low",
                     transmit_data, $time);
            error_count++;
            test_errors++;
        end
        if (transmit_data_valid && expected_words.size() == 0) begin
            $display("Output word %h at time %0t arrived with no payload expected",
                     transmit_data, $time);
            error_count++;
            test_errors++;
        end else if (transmit_data_valid) begin
            check_word(transmit_data, expected_words.pop_front(), "transmit_data");
        end
        receive_data_enable = valid;
        receive_data        = word;
        if (hold_output) begin
            transmit_data_enable = 1'b0;
        end else begin
            transmit_data_enable = next_lfsr_bit() | next_lfsr_bit();   // Mostly high
        end
    endtask

    task automatic send_frame();
        stream_word_t word;
        logic         gap;
        for (int i = 0; i < frame_bytes.size(); i++) begin
            gap = next_lfsr_bit() & next_lfsr_bit();
            if (gap) begin
                step_cycle(1'b0, '0);
            end
            word.last = (i == frame_bytes.size() - 1);
            word.data = frame_bytes[i];
            step_cycle(1'b1, word);
        end
        step_cycle(1'b0, '0);
    endtask

    // Payload sits between the port and the checksum
    task automatic expect_frame(input logic deliver);
        stream_word_t word;
        if (!deliver) begin
            expected_drops++;
        end else if (frame_bytes.size() > 4) begin
            expected_packets++;
            for (int i = 2; i < frame_bytes.size() - 2; i++) begin
                word.last = (i == frame_bytes.size() - 3);
                word.data = frame_bytes[i];
                expected_words.push_back(word);
            end
        end
    endtask

    task automatic build_frame(input port_t port, input int length);
        port_t checksum;
        int    position;
        frame_bytes = {};
        frame_bytes.push_back(port[15:8]);
        frame_bytes.push_back(port[7:0]);
        repeat (length) frame_bytes.push_back(random_byte());
        position = frame_bytes.size();
        frame_bytes.push_back(8'h00);
        frame_bytes.push_back(8'h00);
        checksum = ~ones_sum(frame_bytes);
        // Odd payload puts the checksum across a word boundary
        if (position % 2 == 0) begin
            frame_bytes[position]     = checksum[15:8];
            frame_bytes[position + 1] = checksum[7:0];
        end else begin
            frame_bytes[position]     = checksum[7:0];
            frame_bytes[position + 1] = checksum[15:8];
        end
    endtask

    task automatic load_frame(input string hex);
        string pair;
        frame_bytes = {};
        for (int i = 0; i + 1 < hex.len(); i += 2) begin
            pair = hex.substr(i, i + 1);
            frame_bytes.push_back(byte_t'(pair.atohex()));
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        int waited;
        hold_output = 1'b0;
        waited      = 0;
        while (expected_words.size() != 0 && waited < DRAIN_TIMEOUT) begin
            step_cycle(1'b0, '0);
            waited++;
        end
        if (expected_words.size() != 0) begin
            $display("Timed out in test %s with %0d payload bytes never delivered",
                     name, expected_words.size());
            timed_out = 1'b1;
            error_count++;
            test_errors++;
        end else begin
            repeat (SETTLE_CYCLES) step_cycle(1'b0, '0);
            check_count(packet_count, expected_packets, "packet_count");
            check_count(drop_count, expected_drops, "drop_count");
        end
        report_test(name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reset, trace replay and summary
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int    trace_fd;
        int    items;
        string line;
        string kind;
        string outcome;
        string mode;
        string field_a;
        string field_b;

        rst_n                = 1'b0;
        receive_data         = '0;
        receive_data_enable  = 1'b0;
        transmit_data_enable = 1'b0;
        hold_output          = 1'b0;
        timed_out            = 1'b0;
        lfsr_state           = 16'd90;
        expected_packets     = '0;
        expected_drops       = '0;
        error_count          = 0;
        test_errors          = 0;
        tests_run            = 0;
        tests_failed         = 0;

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        check_flag(transmit_data_valid, 1'b0, "transmit_data_valid after reset");
        check_count(packet_count, '0, "packet_count after reset");
        check_count(drop_count, '0, "drop_count after reset");
        report_test("reset");

        trace_fd = $fopen(TRACE_FILE, "r");
        if (trace_fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
            error_count++;
        end else begin
            while (!timed_out && $fgets(line, trace_fd) != 0) begin
                items = $sscanf(line, "%s %s %s %s %s", kind, outcome, mode, field_a, field_b);
                if (items >= 2 && kind != "#") begin
                    if (kind == "end") begin
                        finish_test(outcome);
                    end else begin
                        hold_output = (mode == "hold");
                        if (kind == "gen") begin
                            build_frame(port_t'(field_a.atohex()), field_b.atoi());
                        end else begin
                            load_frame(field_a);
                        end
                        expect_frame(outcome == "deliver");
                        send_frame();
                    end
                end
            end
            $fclose(trace_fd);
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
